// ==== bench/dma_mem_model.sv ====
`timescale 1ns/100ps

module dma_mem_model import cache_pkg::*; #(
  parameter int ch_p = 0
) (
  input  logic                    clk_i
  , input  logic                  reset_i
  , input  logic [2:0]            stall_i  // pkt ready, rdata valid, wdata ready.

  , input  dma_pkt_t              dma_pkt_i
  , input  logic                  dma_pkt_v_i
  , output logic                  dma_pkt_ready_o

  , output logic [DATA_WIDTH-1:0] dma_rdata_o
  , output logic                  dma_rdata_v_o
  , input  logic                  dma_rdata_ready_i

  , input  logic [DATA_WIDTH-1:0] dma_wdata_i
  , input  logic                  dma_wdata_v_i
  , output logic                  dma_wdata_ready_o

  , input  logic [ADDR_WIDTH-1:0] peek_addr_i
  , output logic [DATA_WIDTH-1:0] peek_data_o
);

  logic [DATA_WIDTH-1:0] mem [2**(ADDR_WIDTH-BYTE_OFFSET_BITS)];

  assign peek_data_o = mem[peek_addr_i[ADDR_WIDTH-1:BYTE_OFFSET_BITS]];

  initial begin : serve
    logic                  rst;
    logic                  pkt_fire;
    logic                  rd_fire;
    logic                  rd_hold;
    logic                  wr_fire;
    dma_pkt_t              pkt;
    logic [DATA_WIDTH-1:0] wdata;
    logic [2:0]            stl;
    int                    rd_left;
    logic                  wr_pend;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [ADDR_WIDTH-1:0] wr_addr;

    for (int w = 0; w < 2**(ADDR_WIDTH-BYTE_OFFSET_BITS); w++)
      mem[w] = {16'hC0DE, 16'(ch_p * 4096 + w * 4)};  // start-up contents.
    dma_pkt_ready_o   = 1'b0;
    dma_rdata_o       = '0;
    dma_rdata_v_o     = 1'b0;
    dma_wdata_ready_o = 1'b0;
    rd_left           = 0;
    wr_pend           = 1'b0;
    rd_addr           = '0;
    wr_addr           = '0;
    forever begin
      @(posedge clk_i);
      rst      = reset_i;
      pkt_fire = dma_pkt_v_i & dma_pkt_ready_o;
      rd_fire  = dma_rdata_v_o & dma_rdata_ready_i;
      rd_hold  = dma_rdata_v_o & ~dma_rdata_ready_i;  // valid may not drop.
      wr_fire  = dma_wdata_v_i & dma_wdata_ready_o;
      pkt      = dma_pkt_i;
      wdata    = dma_wdata_i;
      stl      = stall_i;
      #1;
      if (rst) begin
        rd_left = 0;
        wr_pend = 1'b0;
        rd_hold = 1'b0;
      end else begin
        if (rd_fire) begin
          rd_left = rd_left - 1;
          rd_addr = rd_addr + ADDR_WIDTH'(DATA_WIDTH / 8);
        end
        if (wr_fire) begin
          mem[wr_addr[ADDR_WIDTH-1:BYTE_OFFSET_BITS]] = wdata;
          wr_pend = 1'b0;
        end
        if (pkt_fire && pkt.write_not_read) begin
          wr_pend = 1'b1;
          wr_addr = pkt.addr;
        end else if (pkt_fire) begin
          rd_left = BLOCK_WORDS;  // one block per read.
          rd_addr = pkt.addr;
        end
      end
      dma_pkt_ready_o   = !rst && rd_left == 0 && !wr_pend && !stl[0];
      dma_rdata_v_o     = rd_left != 0 && (rd_hold || !stl[1]);
      dma_rdata_o       = mem[rd_addr[ADDR_WIDTH-1:BYTE_OFFSET_BITS]];
      dma_wdata_ready_o = wr_pend && !stl[2];
    end
  end

endmodule

// ==== bench/tb_test_master.sv ====
`timescale 1ns/100ps

module tb_test_master import cache_pkg::*; ();

  logic                                  clk;
  logic                                  reset;
  dma_pkt_t [NUM_CACHE-1:0]              dma_pkt;
  logic [NUM_CACHE-1:0]                  dma_pkt_v, dma_pkt_ready;
  logic [NUM_CACHE-1:0][DATA_WIDTH-1:0]  dma_rdata, dma_wdata;
  logic [NUM_CACHE-1:0]                  dma_rdata_v, dma_rdata_ready;
  logic [NUM_CACHE-1:0]                  dma_wdata_v, dma_wdata_ready;
  logic                                  done, error;
  logic [NUM_CACHE-1:0][2:0]             stall;
  logic [NUM_CACHE-1:0][ADDR_WIDTH-1:0]  peek_addr;
  logic [NUM_CACHE-1:0][DATA_WIDTH-1:0]  peek_data;

  // monitor state per channel.
  logic [ADDR_WIDTH-1:0] wr_addr [NUM_CACHE];
  logic [NUM_CACHE-1:0]  wr_pend;
  int                    rd_left [NUM_CACHE];

  test_master test_master_i (
    .clk_i(clk), .reset_i(reset)
    ,.dma_pkt_o(dma_pkt), .dma_pkt_v_o(dma_pkt_v), .dma_pkt_ready_i(dma_pkt_ready)
    ,.dma_rdata_i(dma_rdata), .dma_rdata_v_i(dma_rdata_v), .dma_rdata_ready_o(dma_rdata_ready)
    ,.dma_wdata_o(dma_wdata), .dma_wdata_v_o(dma_wdata_v), .dma_wdata_ready_i(dma_wdata_ready)
    ,.done_o(done), .error_o(error)
  );

  for (genvar i = 0; i < NUM_CACHE; i++) begin : mem_ch
    dma_mem_model #(.ch_p(i)) mem_model (
      .clk_i(clk), .reset_i(reset), .stall_i(stall[i])
      ,.dma_pkt_i(dma_pkt[i]), .dma_pkt_v_i(dma_pkt_v[i]), .dma_pkt_ready_o(dma_pkt_ready[i])
      ,.dma_rdata_o(dma_rdata[i]), .dma_rdata_v_o(dma_rdata_v[i])
      ,.dma_rdata_ready_i(dma_rdata_ready[i])
      ,.dma_wdata_i(dma_wdata[i]), .dma_wdata_v_i(dma_wdata_v[i])
      ,.dma_wdata_ready_o(dma_wdata_ready[i])
      ,.peek_addr_i(peek_addr[i]), .peek_data_o(peek_data[i])
    );
  end

  //////////////////////////////
  // reference model
  function automatic logic [DATA_WIDTH-1:0] store_value(input int unsigned ch,
                                                        input int unsigned k);
    return DATA_WIDTH'(ch * 65536 + k * 257 + 4096);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] init_value(input int unsigned ch,
                                                       input int unsigned addr);
    return {16'hC0DE, 16'((ch * 4096 + addr) % 65536)};
  endfunction

  task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                             input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic wait_for_done(input int limit);
    int cycles;
    cycles = 0;
    while (!done && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) begin
      $display("timeout: done_o did not rise within %0d cycles", limit);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  endtask

  //////////////////////////////
  // clock, stalls, monitor
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    void'($urandom(32'h3041));
    stall = '0;
    forever begin
      @(posedge clk);
      #1;
      for (int i = 0; i < NUM_CACHE; i++)
        for (int b = 0; b < 3; b++)
          stall[i][b] = ($urandom % 3) == 0;  // about one cycle in three.
    end
  end

  always @(negedge clk) begin : monitor
    int k;
    if (reset) begin
      wr_pend = '0;
      for (int i = 0; i < NUM_CACHE; i++) rd_left[i] = 0;
    end else begin
      check_value("error_o", error, 0);
      for (int i = 0; i < NUM_CACHE; i++) begin
        if (dma_wdata_v[i])
          check_value($sformatf("write packet before data ch%0d", i), wr_pend[i], 1);
        if (dma_wdata_v[i] && dma_wdata_ready[i]) begin
          k = int'(wr_addr[i] >> 4);
          check_value($sformatf("dma write addr ch%0d", i), wr_addr[i], ADDR_WIDTH'(k * 16));
          check_value($sformatf("dma write k in range ch%0d", i), k < 16, 1);
          check_value($sformatf("dma_wdata_o[%0d]", i), dma_wdata[i], store_value(i, k));
          wr_pend[i] = 1'b0;
        end
        if (dma_rdata_ready[i])
          check_value($sformatf("read word expected ch%0d", i), rd_left[i] > 0, 1);
        if (dma_rdata_v[i] && dma_rdata_ready[i])
          rd_left[i] = rd_left[i] - 1;
        if (dma_pkt_v[i]) begin
          check_value($sformatf("write overlap ch%0d", i), wr_pend[i], 0);
          check_value($sformatf("read burst complete ch%0d", i), rd_left[i] == 0, 1);
        end
        if (dma_pkt_v[i] && dma_pkt_ready[i]) begin
          if (dma_pkt[i].write_not_read) begin
            wr_pend[i] = 1'b1;
            wr_addr[i] = dma_pkt[i].addr;
          end else begin
            check_value($sformatf("dma read addr offset ch%0d", i),
                        dma_pkt[i].addr[OFFSET_BITS-1:0], 0);  // block aligned.
            rd_left[i] = BLOCK_WORDS;
          end
        end
      end
    end
  end

  //////////////////////////////
  // main sequence
  initial begin
    logic [DATA_WIDTH-1:0] exp;
    reset     = 1'b1;
    peek_addr = '0;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    wait_for_done(20000);

    // memory image after the run.
    for (int i = 0; i < NUM_CACHE; i++) begin
      for (int a = 0; a < 2**ADDR_WIDTH; a += DATA_WIDTH / 8) begin
        peek_addr[i] = ADDR_WIDTH'(a);
        #1;
        if (a % 16 == 0 && a < 256) exp = store_value(i, a / 16);
        else exp = init_value(i, a);
        check_value($sformatf("mem ch%0d addr %h", i, a), peek_data[i], exp);
      end
      check_value($sformatf("open read burst ch%0d", i), rd_left[i], 0);
      check_value($sformatf("open write ch%0d", i), wr_pend[i], 0);
    end

    if (error) begin
      $display("error_o is high at the end of the run");
      $display("Test failures found");
      $fatal(1, "replayer reported an error");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
hdl/cache_pkg.sv
hdl/trace_rom.sv
hdl/trace_replay.sv
hdl/dm_cache.sv
hdl/test_master.sv
bench/dma_mem_model.sv
bench/tb_test_master.sv

// ==== hdl/cache_pkg.sv ====
package cache_pkg;

  //////////////////////////////
  // sizes
  localparam int NUM_CACHE   = 2;
  localparam int ADDR_WIDTH  = 12;  // byte address.
  localparam int DATA_WIDTH  = 32;
  localparam int BLOCK_WORDS = 4;
  localparam int SETS        = 8;

  localparam int BYTE_OFFSET_BITS = $clog2(DATA_WIDTH / 8);
  localparam int WORD_BITS        = $clog2(BLOCK_WORDS);
  localparam int OFFSET_BITS      = WORD_BITS + BYTE_OFFSET_BITS;
  localparam int INDEX_BITS       = $clog2(SETS);
  localparam int TAG_BITS         = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

  // program is 65 entries long, so one more bit than 64 entries need.
  localparam int TRACE_ADDR_WIDTH = 7;

  //////////////////////////////
  // packets
  typedef enum logic {op_load, op_store} cache_op_e;

  typedef struct packed {
    cache_op_e               opcode;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   data;
  } cache_pkt_t;

  typedef struct packed {
    logic                    write_not_read;  // write moves one word.
    logic [ADDR_WIDTH-1:0]   addr;            // read moves a block.
  } dma_pkt_t;

  typedef enum logic [1:0] {tr_send, tr_recv, tr_done} trace_cmd_e;

  typedef struct packed {
    trace_cmd_e              cmd;
    cache_pkt_t              pkt;  // recv keeps expected word in data.
  } trace_entry_t;

  // memory contents before any store.
  function automatic logic [DATA_WIDTH-1:0] init_word(input int unsigned ch,
                                                      input logic [ADDR_WIDTH-1:0] addr);
    logic [15:0] low;
    low = 16'(ch * 4096 + int'(addr));
    return {16'hC0DE, low};
  endfunction

endpackage

// ==== hdl/dm_cache.sv ====
`timescale 1ns/100ps

module dm_cache import cache_pkg::*; (
  input  logic                    clk_i
  , input  logic                  reset_i

  , input  cache_pkt_t            req_i
  , input  logic                  req_v_i
  , output logic                  req_ready_o

  , output logic [DATA_WIDTH-1:0] resp_data_o
  , output logic                  resp_v_o
  , input  logic                  resp_ready_i

  , output dma_pkt_t              dma_pkt_o
  , output logic                  dma_pkt_v_o
  , input  logic                  dma_pkt_ready_i

  , input  logic [DATA_WIDTH-1:0] dma_rdata_i
  , input  logic                  dma_rdata_v_i
  , output logic                  dma_rdata_ready_o

  , output logic [DATA_WIDTH-1:0] dma_wdata_o
  , output logic                  dma_wdata_v_o
  , input  logic                  dma_wdata_ready_i
);

  typedef enum logic [2:0] {
    s_idle, s_lookup, s_fill_req, s_fill, s_wr_req, s_wr_data, s_resp
  } state_e;

  state_e                  state_r;
  cache_pkt_t              req_r;
  logic [DATA_WIDTH-1:0]   resp_data_r;
  logic [WORD_BITS-1:0]    fill_cnt_r;
  logic [SETS-1:0]         valid_r;
  logic [TAG_BITS-1:0]     tag_r  [SETS];
  logic [DATA_WIDTH-1:0]   data_r [SETS][BLOCK_WORDS];

  logic [INDEX_BITS-1:0]   idx;
  logic [TAG_BITS-1:0]     req_tag;
  logic [WORD_BITS-1:0]    word_sel;
  logic                    hit;
  logic [DATA_WIDTH-1:0]   hit_word;
  logic                    fill_last;

  assign idx      = req_r.addr[OFFSET_BITS +: INDEX_BITS];
  assign req_tag  = req_r.addr[ADDR_WIDTH-1 -: TAG_BITS];
  assign word_sel = req_r.addr[BYTE_OFFSET_BITS +: WORD_BITS];
  assign hit      = valid_r[idx] && (tag_r[idx] == req_tag);
  assign hit_word = data_r[idx][word_sel];
  assign fill_last = (state_r == s_fill) && dma_rdata_v_i
                     && (fill_cnt_r == WORD_BITS'(BLOCK_WORDS - 1));

  //////////////////////////////
  // handshakes
  assign req_ready_o       = (state_r == s_idle);
  assign resp_v_o          = (state_r == s_resp)
                             || (state_r == s_lookup && req_r.opcode == op_load && hit);
  assign resp_data_o       = (state_r == s_resp) ? resp_data_r : hit_word;
  assign dma_pkt_v_o       = (state_r == s_fill_req) || (state_r == s_wr_req);
  assign dma_rdata_ready_o = (state_r == s_fill);
  assign dma_wdata_v_o     = (state_r == s_wr_data);
  assign dma_wdata_o       = req_r.data;

  always_comb begin
    dma_pkt_o.write_not_read = (state_r == s_wr_req);
    if (state_r == s_wr_req)
      dma_pkt_o.addr = {req_r.addr[ADDR_WIDTH-1:BYTE_OFFSET_BITS], BYTE_OFFSET_BITS'(0)};
    else
      dma_pkt_o.addr = {req_r.addr[ADDR_WIDTH-1:OFFSET_BITS], OFFSET_BITS'(0)};
  end

  //////////////////////////////
  // control
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= s_idle;
      valid_r    <= '0;
      fill_cnt_r <= '0;
    end else begin
      case (state_r)
        s_idle: if (req_v_i) state_r <= s_lookup;
        s_lookup: begin
          if (req_r.opcode == op_store) state_r <= s_wr_req;  // write through.
          else if (!hit) state_r <= s_fill_req;
          else if (!resp_ready_i) state_r <= s_resp;
          else state_r <= s_idle;
        end
        s_fill_req: begin
          if (dma_pkt_ready_i) begin
            state_r    <= s_fill;
            fill_cnt_r <= '0;
          end
        end
        s_fill: begin
          if (dma_rdata_v_i) fill_cnt_r <= fill_cnt_r + 1'b1;
          if (fill_last) begin
            valid_r[idx] <= 1'b1;
            state_r      <= s_resp;
          end
        end
        s_wr_req:  if (dma_pkt_ready_i) state_r <= s_wr_data;
        s_wr_data: if (dma_wdata_ready_i) state_r <= s_resp;
        s_resp:    if (resp_ready_i) state_r <= s_idle;
        default:   state_r <= s_idle;
      endcase
    end
  end

  // arrays and payload.
  always_ff @(posedge clk_i) begin
    if (req_v_i && req_ready_o) req_r <= req_i;
    if (state_r == s_lookup) resp_data_r <= hit_word;
    if (state_r == s_fill && dma_rdata_v_i && fill_cnt_r == word_sel)
      resp_data_r <= dma_rdata_i;  // requested word.
    if (state_r == s_wr_data) resp_data_r <= '0;
    if (state_r == s_lookup && req_r.opcode == op_store && hit)
      data_r[idx][word_sel] <= req_r.data;  // no allocate on miss.
    if (state_r == s_fill && dma_rdata_v_i) data_r[idx][fill_cnt_r] <= dma_rdata_i;
    if (fill_last) tag_r[idx] <= req_tag;
  end

  //////////////////////////////
  // assertions
  assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(dma_pkt_v_o) |-> $past(state_r) == s_lookup)
    else $error("dma packet not started from lookup");
  assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(dma_wdata_v_o) |-> $past(dma_pkt_v_o && dma_pkt_ready_i && dma_pkt_o.write_not_read))
    else $error("write data without write packet");
  assert property (@(posedge clk_i) disable iff (reset_i)
    dma_pkt_v_o && !dma_pkt_ready_i |=> dma_pkt_v_o && $stable(dma_pkt_o))
    else $error("dma packet changed while stalled");
  assert property (@(posedge clk_i) disable iff (reset_i)
    dma_wdata_v_o && !dma_wdata_ready_i |=> dma_wdata_v_o && $stable(dma_wdata_o))
    else $error("dma write data changed while stalled");
  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o && !resp_ready_i |=> resp_v_o && $stable(resp_data_o))
    else $error("response changed while stalled");

endmodule

// ==== hdl/test_master.sv ====
`timescale 1ns/100ps

module test_master import cache_pkg::*; (
  input  logic                                  clk_i
  , input  logic                                reset_i

  , output dma_pkt_t [NUM_CACHE-1:0]            dma_pkt_o
  , output logic [NUM_CACHE-1:0]                dma_pkt_v_o
  , input  logic [NUM_CACHE-1:0]                dma_pkt_ready_i

  , input  logic [NUM_CACHE-1:0][DATA_WIDTH-1:0] dma_rdata_i
  , input  logic [NUM_CACHE-1:0]                dma_rdata_v_i
  , output logic [NUM_CACHE-1:0]                dma_rdata_ready_o

  , output logic [NUM_CACHE-1:0][DATA_WIDTH-1:0] dma_wdata_o
  , output logic [NUM_CACHE-1:0]                dma_wdata_v_o
  , input  logic [NUM_CACHE-1:0]                dma_wdata_ready_i

  , output logic                                done_o
  , output logic                                error_o
);

  cache_pkt_t [NUM_CACHE-1:0]                   req;
  logic [NUM_CACHE-1:0]                         req_v, req_ready;
  logic [NUM_CACHE-1:0][DATA_WIDTH-1:0]         resp_data;
  logic [NUM_CACHE-1:0]                         resp_v, resp_ready;
  logic [NUM_CACHE-1:0][TRACE_ADDR_WIDTH-1:0]   rom_addr;
  trace_entry_t [NUM_CACHE-1:0]                 rom_data;
  logic [NUM_CACHE-1:0]                         done, error;

  for (genvar i = 0; i < NUM_CACHE; i++) begin : ch
    trace_rom #(.id_p(i)) rom (
      .rom_addr_i(rom_addr[i])
      ,.rom_data_o(rom_data[i])
    );

    trace_replay replay (
      .clk_i(clk_i), .reset_i(reset_i)
      ,.req_o(req[i]), .req_v_o(req_v[i]), .req_ready_i(req_ready[i])
      ,.resp_data_i(resp_data[i]), .resp_v_i(resp_v[i]), .resp_ready_o(resp_ready[i])
      ,.rom_addr_o(rom_addr[i]), .rom_data_i(rom_data[i])
      ,.done_o(done[i]), .error_o(error[i])
    );

    dm_cache cache (
      .clk_i(clk_i), .reset_i(reset_i)
      ,.req_i(req[i]), .req_v_i(req_v[i]), .req_ready_o(req_ready[i])
      ,.resp_data_o(resp_data[i]), .resp_v_o(resp_v[i]), .resp_ready_i(resp_ready[i])
      ,.dma_pkt_o(dma_pkt_o[i]), .dma_pkt_v_o(dma_pkt_v_o[i])
      ,.dma_pkt_ready_i(dma_pkt_ready_i[i])
      ,.dma_rdata_i(dma_rdata_i[i]), .dma_rdata_v_i(dma_rdata_v_i[i])
      ,.dma_rdata_ready_o(dma_rdata_ready_o[i])
      ,.dma_wdata_o(dma_wdata_o[i]), .dma_wdata_v_o(dma_wdata_v_o[i])
      ,.dma_wdata_ready_i(dma_wdata_ready_i[i])
    );
  end

  assign done_o  = &done;   // all channels finished.
  assign error_o = |error;

endmodule

// ==== hdl/trace_replay.sv ====
`timescale 1ns/100ps

module trace_replay import cache_pkg::*; (
  input  logic                        clk_i
  , input  logic                      reset_i

  , output cache_pkt_t                req_o
  , output logic                      req_v_o
  , input  logic                      req_ready_i

  , input  logic [DATA_WIDTH-1:0]     resp_data_i
  , input  logic                      resp_v_i
  , output logic                      resp_ready_o

  , output logic [TRACE_ADDR_WIDTH-1:0] rom_addr_o
  , input  trace_entry_t              rom_data_i

  , output logic                      done_o
  , output logic                      error_o
);

  trace_entry_t                entry;
  logic [TRACE_ADDR_WIDTH-1:0] pc_r;
  logic                        outstanding_r;
  logic                        store_pend_r;
  logic                        done_r;
  logic                        error_r;
  logic                        req_fire;
  logic                        resp_fire;
  logic                        recv_fire;

  assign entry      = rom_data_i;
  assign rom_addr_o = pc_r;

  assign req_o        = entry.pkt;
  assign req_v_o      = (entry.cmd == tr_send) & ~outstanding_r;
  assign resp_ready_o = outstanding_r & (store_pend_r | (entry.cmd == tr_recv));

  assign req_fire  = req_v_o & req_ready_i;
  assign resp_fire = resp_v_i & resp_ready_o;
  assign recv_fire = resp_fire & ~store_pend_r;  // store replies are dropped.

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r          <= '0;
      outstanding_r <= 1'b0;
      store_pend_r  <= 1'b0;
      done_r        <= 1'b0;
      error_r       <= 1'b0;
    end else begin
      if (req_fire) begin
        pc_r          <= pc_r + 1'b1;
        outstanding_r <= 1'b1;
        store_pend_r  <= (entry.pkt.opcode == op_store);
      end else if (resp_fire) begin
        outstanding_r <= 1'b0;
        store_pend_r  <= 1'b0;
      end
      if (recv_fire) begin
        pc_r <= pc_r + 1'b1;
        if (resp_data_i != entry.pkt.data) error_r <= 1'b1;  // sticky.
      end
      if (entry.cmd == tr_done && !outstanding_r) done_r <= 1'b1;
    end
  end

  assign done_o  = done_r;
  assign error_o = error_r;

  // cache must never answer a request it was not given.
  assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_i |-> outstanding_r)
    else $error("response with no request outstanding");

endmodule

// ==== hdl/trace_rom.sv ====
`timescale 1ns/100ps

module trace_rom import cache_pkg::*; #(
  parameter int id_p = 0
) (
  input  logic [TRACE_ADDR_WIDTH-1:0] rom_addr_i
  , output trace_entry_t              rom_data_o
);

  logic [TRACE_ADDR_WIDTH-1:0] ofs;
  logic [3:0]                  k;
  logic [ADDR_WIDTH-1:0]       k_addr;

  function automatic logic [DATA_WIDTH-1:0] store_word(input logic [3:0] idx);
    return DATA_WIDTH'(id_p) * 32'h10000 + DATA_WIDTH'(idx) * 32'd257 + 32'h1000;
  endfunction

  assign k_addr = ADDR_WIDTH'(k) << 4;

  always_comb begin
    ofs        = '0;
    k          = '0;
    rom_data_o = '0;
    rom_data_o.cmd = tr_done;
    if (rom_addr_i < 16) begin  // stores.
      k = rom_addr_i[3:0];
      rom_data_o.cmd        = tr_send;
      rom_data_o.pkt.opcode = op_store;
      rom_data_o.pkt.addr   = k_addr;
      rom_data_o.pkt.data   = store_word(k);
    end else if (rom_addr_i < 48) begin  // reload stored words.
      ofs = rom_addr_i - TRACE_ADDR_WIDTH'(16);
      k   = ofs[4:1];
      rom_data_o.cmd        = ofs[0] ? tr_recv : tr_send;
      rom_data_o.pkt.opcode = op_load;
      rom_data_o.pkt.addr   = k_addr;
      rom_data_o.pkt.data   = ofs[0] ? store_word(k) : '0;
    end else if (rom_addr_i < 64) begin  // untouched region.
      ofs = rom_addr_i - TRACE_ADDR_WIDTH'(48);
      k   = {1'b0, ofs[3:1]};
      rom_data_o.cmd        = ofs[0] ? tr_recv : tr_send;
      rom_data_o.pkt.opcode = op_load;
      rom_data_o.pkt.addr   = ADDR_WIDTH'(1024) + k_addr;
      rom_data_o.pkt.data   = ofs[0] ? init_word(id_p, ADDR_WIDTH'(1024) + k_addr) : '0;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module tb_test_master -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"
grep -q 'All tests passed!' <<< "$out"
